//--- hdl/riscv_pkg.sv
package riscv_pkg;

  localparam int XLEN = 32;

  // ----------------------------------------------------------------------
  // Major opcodes
  // ----------------------------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Full encodings of the privileged instructions
  localparam logic [XLEN-1:0] INSTR_ECALL = 32'h0000_0073;
  localparam logic [XLEN-1:0] INSTR_MRET  = 32'h3020_0073;

  typedef enum logic {
    UNIT_ALU,
    UNIT_CSR
  } unit_e;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_CSRRW,
    OP_CSRRS,
    OP_CSRRC
  } operation_e;

  // ----------------------------------------------------------------------
  // Decoder output
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic            rd_v;
    logic [4:0]      rd_adr;
    logic            rs1_v;
    logic [4:0]      rs1_adr;
    logic            rs2_v;
    logic [4:0]      rs2_adr;
    logic            rs1_is_imm;
    logic            rs2_is_imm;
    logic            rs2_is_csr;
    logic            auipc;
    logic            csr_wbk;
    logic [11:0]     csr_adr;
    logic            csr_clear;
    logic [XLEN-1:0] imm;
    logic            unsign_ext;
    logic            rs2_neg;
    unit_e           unit;
    operation_e      operation;
    logic            illegal;
    logic            ecall;
    logic            mret;
  } instr_info_t;

endpackage

//--- hdl/pipe_pkg.sv
package pipe_pkg;

  // ----------------------------------------------------------------------
  // Decode to execute stage register
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                       rd_v;
    logic [4:0]                 rd_adr;
    logic                       csr_wbk;
    logic [11:0]                csr_adr;
    // Extra top bit is the sign, or zero for unsigned compares
    logic [riscv_pkg::XLEN:0]   rs1_qual;
    logic [riscv_pkg::XLEN:0]   rs2_qual;
    riscv_pkg::unit_e           unit;
    riscv_pkg::operation_e      operation;
    logic                       illegal;
    logic                       ecall;
    logic                       mret;
  } dec_exe_t;

  // Register result, used for forwards and the RF write port
  typedef struct packed {
    logic                       v;
    logic [4:0]                 adr;
    logic [riscv_pkg::XLEN-1:0] data;
  } fwd_t;

  // CSR result
  typedef struct packed {
    logic                       v;
    logic [11:0]                adr;
    logic [riscv_pkg::XLEN-1:0] data;
  } csr_fwd_t;

endpackage

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  logic [riscv_pkg::XLEN-1:0] instr_i,
  output riscv_pkg::instr_info_t     info_o
);

  logic [6:0]                 opcode;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  logic [riscv_pkg::XLEN-1:0] imm_i;
  logic [riscv_pkg::XLEN-1:0] imm_u;
  // funct3 decode shared by register and immediate ALU forms
  logic                       alu_ok;
  logic                       alu_neg;
  logic                       alu_unsigned;
  riscv_pkg::operation_e      alu_op;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u  = {instr_i[31:12], 12'b0};

  always_comb begin
    alu_ok       = 1'b1;
    alu_neg      = 1'b0;
    alu_unsigned = 1'b0;
    alu_op       = riscv_pkg::OP_ADD;
    case (funct3)
      3'b000: alu_op = riscv_pkg::OP_ADD;
      3'b010: begin
        alu_op  = riscv_pkg::OP_SLT;
        alu_neg = 1'b1;
      end
      3'b011: begin
        alu_op       = riscv_pkg::OP_SLT;
        alu_neg      = 1'b1;
        alu_unsigned = 1'b1;
      end
      3'b100: alu_op = riscv_pkg::OP_XOR;
      3'b110: alu_op = riscv_pkg::OP_OR;
      3'b111: alu_op = riscv_pkg::OP_AND;
      // Shifts are not supported
      default: alu_ok = 1'b0;
    endcase
  end

  always_comb begin
    info_o           = '0;
    info_o.rs1_adr   = instr_i[19:15];
    info_o.rs2_adr   = instr_i[24:20];
    info_o.csr_adr   = instr_i[31:20];
    info_o.imm       = imm_i;
    info_o.unit      = riscv_pkg::UNIT_ALU;
    info_o.operation = riscv_pkg::OP_ADD;
    info_o.illegal   = 1'b1;

    case (opcode)
      riscv_pkg::OPC_OP: begin
        info_o.rs1_v      = 1'b1;
        info_o.rs2_v      = 1'b1;
        info_o.operation  = alu_op;
        info_o.unsign_ext = alu_unsigned;
        // SUB is ADD with the alternate funct7 and a negated rs2
        info_o.rs2_neg    = alu_neg || funct7[5];
        info_o.illegal    = !alu_ok ||
                            !(funct7 == 7'b0000000 ||
                              (funct7 == 7'b0100000 && funct3 == 3'b000));
      end
      riscv_pkg::OPC_OP_IMM: begin
        info_o.rs1_v      = 1'b1;
        info_o.rs2_is_imm = 1'b1;
        info_o.operation  = alu_op;
        info_o.unsign_ext = alu_unsigned;
        info_o.rs2_neg    = alu_neg;
        info_o.illegal    = !alu_ok;
      end
      riscv_pkg::OPC_LUI: begin
        info_o.rs1_is_imm = 1'b1;
        info_o.imm        = imm_u;
        info_o.illegal    = 1'b0;
      end
      riscv_pkg::OPC_AUIPC: begin
        info_o.auipc      = 1'b1;
        info_o.rs2_is_imm = 1'b1;
        info_o.imm        = imm_u;
        info_o.illegal    = 1'b0;
      end
      riscv_pkg::OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          info_o.ecall   = (instr_i == riscv_pkg::INSTR_ECALL);
          info_o.mret    = (instr_i == riscv_pkg::INSTR_MRET);
          info_o.illegal = !(info_o.ecall || info_o.mret);
        end else if (!funct3[2]) begin
          // Register CSR forms only, immediate forms stay illegal
          info_o.rs1_v      = 1'b1;
          info_o.rs2_is_csr = 1'b1;
          info_o.unit       = riscv_pkg::UNIT_CSR;
          info_o.unsign_ext = 1'b1;
          info_o.csr_clear  = (funct3 == 3'b011);
          // Set and clear with rs1 = x0 only read the CSR
          info_o.csr_wbk    = (funct3 == 3'b001) || (instr_i[19:15] != 5'd0);
          info_o.illegal    = 1'b0;
          case (funct3[1:0])
            2'b01:   info_o.operation = riscv_pkg::OP_CSRRW;
            2'b10:   info_o.operation = riscv_pkg::OP_CSRRS;
            default: info_o.operation = riscv_pkg::OP_CSRRC;
          endcase
        end
      end
      default: info_o.illegal = 1'b1;
    endcase

    // x0 is never a destination, so it never forwards
    info_o.rd_adr = instr_i[11:7];
    info_o.rd_v   = !info_o.illegal && (instr_i[11:7] != 5'd0);
  end

endmodule

//--- hdl/dec.sv
`timescale 1ns/1ps

module dec #(
  parameter int          NB_CSR   = 4,
  parameter logic [11:0] CSR_BASE = 12'h340
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic [riscv_pkg::XLEN-1:0] instr_i,
  input  logic [riscv_pkg::XLEN-1:0] pc_i,
  input  logic                       flush_i,
  output logic [4:0]                 rf_rs1_adr_o,
  output logic [4:0]                 rf_rs2_adr_o,
  input  logic [riscv_pkg::XLEN-1:0] rf_rs1_data_i,
  input  logic [riscv_pkg::XLEN-1:0] rf_rs2_data_i,
  output logic [11:0]                csr_adr_o,
  input  logic [riscv_pkg::XLEN-1:0] csr_data_i,
  input  pipe_pkg::fwd_t             exe_fwd_i,
  input  pipe_pkg::csr_fwd_t         csr_fwd_i,
  input  pipe_pkg::fwd_t             wbk_fwd_i,
  output pipe_pkg::dec_exe_t         dec_exe_q_o
);

  localparam int XLEN = riscv_pkg::XLEN;

  riscv_pkg::instr_info_t info;
  logic                   reset_n_q;
  logic [11:0]            csr_ofs;
  logic                   csr_fwd_hit;
  logic [XLEN-1:0]        rs1_reg;
  logic [XLEN-1:0]        rs2_reg;
  logic [XLEN-1:0]        rs1_data;
  logic [XLEN-1:0]        rs2_data;
  logic [XLEN:0]          rs2_ext;
  pipe_pkg::dec_exe_t     dec_exe_nxt;

  // Execute result wins over writeback, which wins over the RF
  function automatic logic [XLEN-1:0] fwd_mux(
    input logic [4:0]      adr,
    input logic [XLEN-1:0] rf_data,
    input pipe_pkg::fwd_t  exe_fwd,
    input pipe_pkg::fwd_t  wbk_fwd
  );
    if (exe_fwd.v && exe_fwd.adr == adr) begin
      return exe_fwd.data;
    end else if (wbk_fwd.v && wbk_fwd.adr == adr) begin
      return wbk_fwd.data;
    end
    return rf_data;
  endfunction

  decoder i_decoder (
    .instr_i (instr_i),
    .info_o  (info)
  );

  // ----------------------------------------------------------------------
  // Operand fetch
  // ----------------------------------------------------------------------
  assign rf_rs1_adr_o = info.rs1_adr;
  assign rf_rs2_adr_o = info.rs2_adr;
  assign csr_adr_o    = info.csr_adr;

  assign rs1_reg = fwd_mux(info.rs1_adr, rf_rs1_data_i, exe_fwd_i, wbk_fwd_i);
  assign rs2_reg = fwd_mux(info.rs2_adr, rf_rs2_data_i, exe_fwd_i, wbk_fwd_i);

  // A pending write to an unimplemented CSR must still read as zero
  assign csr_ofs     = info.csr_adr - CSR_BASE;
  assign csr_fwd_hit = csr_fwd_i.v && (csr_fwd_i.adr == info.csr_adr) && (csr_ofs < NB_CSR);

  assign rs1_data = info.rs1_v      ? rs1_reg :
                    info.rs1_is_imm ? info.imm :
                    info.auipc      ? pc_i : '0;

  assign rs2_data = info.rs2_v      ? rs2_reg :
                    info.rs2_is_imm ? info.imm :
                    info.rs2_is_csr ? (csr_fwd_hit ? csr_fwd_i.data : csr_data_i) : '0;

  // ----------------------------------------------------------------------
  // Operand qualification and stage register
  // ----------------------------------------------------------------------
  assign rs2_ext = {!info.unsign_ext && rs2_data[XLEN-1], rs2_data};

  always_comb begin
    dec_exe_nxt.rd_v      = info.rd_v && !flush_i;
    dec_exe_nxt.rd_adr    = info.rd_adr;
    dec_exe_nxt.csr_wbk   = info.csr_wbk && !flush_i;
    dec_exe_nxt.csr_adr   = info.csr_adr;
    // CSRRC carries ~rs1 so execute only has to AND
    dec_exe_nxt.rs1_qual  = {!info.unsign_ext && rs1_data[XLEN-1],
                             info.csr_clear ? ~rs1_data : rs1_data};
    dec_exe_nxt.rs2_qual  = info.rs2_neg ? (~rs2_ext + 1'b1) : rs2_ext;
    dec_exe_nxt.unit      = info.unit;
    dec_exe_nxt.operation = info.operation;
    // No illegal flag on the first word after reset
    dec_exe_nxt.illegal   = info.illegal && reset_n_q && !flush_i;
    dec_exe_nxt.ecall     = info.ecall && !flush_i;
    dec_exe_nxt.mret      = info.mret && !flush_i;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      reset_n_q   <= 1'b0;
      dec_exe_q_o <= '0;
    end else begin
      reset_n_q   <= 1'b1;
      dec_exe_q_o <= dec_exe_nxt;
    end
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic [4:0]                 rs1_adr_i,
  input  logic [4:0]                 rs2_adr_i,
  output logic [riscv_pkg::XLEN-1:0] rs1_data_o,
  output logic [riscv_pkg::XLEN-1:0] rs2_data_o,
  input  pipe_pkg::fwd_t             wr_i
);

  // x0 has no storage
  logic [riscv_pkg::XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.v && wr_i.adr != 5'd0) begin
      regs_q[wr_i.adr] <= wr_i.data;
    end
  end

  // Asynchronous reads
  assign rs1_data_o = (rs1_adr_i == 5'd0) ? '0 : regs_q[rs1_adr_i];
  assign rs2_data_o = (rs2_adr_i == 5'd0) ? '0 : regs_q[rs2_adr_i];

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file #(
  parameter int          NB_CSR   = 4,
  parameter logic [11:0] CSR_BASE = 12'h340
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic [11:0]                rd_adr_i,
  output logic [riscv_pkg::XLEN-1:0] rd_data_o,
  input  pipe_pkg::csr_fwd_t         wr_i
);

  localparam int IDX_W = (NB_CSR > 1) ? $clog2(NB_CSR) : 1;

  logic [11:0]                rd_ofs;
  logic [11:0]                wr_ofs;
  logic                       rd_hit;
  logic                       wr_hit;
  logic [riscv_pkg::XLEN-1:0] csr_q [NB_CSR];

  // ----------------------------------------------------------------------
  // Address decode, bank spans CSR_BASE up to CSR_BASE+NB_CSR-1
  // ----------------------------------------------------------------------
  assign rd_ofs = rd_adr_i - CSR_BASE;
  assign wr_ofs = wr_i.adr - CSR_BASE;
  assign rd_hit = (rd_ofs < NB_CSR);
  assign wr_hit = wr_i.v && (wr_ofs < NB_CSR);

  // Unimplemented addresses read zero
  assign rd_data_o = rd_hit ? csr_q[rd_ofs[IDX_W-1:0]] : '0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < NB_CSR; i++) begin
        csr_q[i] <= '0;
      end
    end else if (wr_hit) begin
      csr_q[wr_ofs[IDX_W-1:0]] <= wr_i.data;
    end
  end

endmodule

//--- hdl/exe.sv
`timescale 1ns/1ps

module exe (
  input  logic               clk,
  input  logic               reset_n,
  input  pipe_pkg::dec_exe_t dec_exe_i,
  output pipe_pkg::fwd_t     exe_fwd_o,
  output pipe_pkg::csr_fwd_t csr_fwd_o,
  output pipe_pkg::fwd_t     wbk_q_o,
  output logic               illegal_q_o,
  output logic               ecall_q_o,
  output logic               mret_q_o
);

  localparam int XLEN = riscv_pkg::XLEN;

  logic [XLEN:0]   sum;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] csr_new;

  // rs2 already negated for SUB and compares
  assign sum = dec_exe_i.rs1_qual + dec_exe_i.rs2_qual;
  assign rs1 = dec_exe_i.rs1_qual[XLEN-1:0];
  assign rs2 = dec_exe_i.rs2_qual[XLEN-1:0];

  always_comb begin
    alu_res = sum[XLEN-1:0];
    csr_new = rs1;
    case (dec_exe_i.operation)
      // Top bit of the 33-bit difference is the less-than result
      riscv_pkg::OP_SLT:   alu_res = {{(XLEN-1){1'b0}}, sum[XLEN]};
      riscv_pkg::OP_AND:   alu_res = rs1 & rs2;
      riscv_pkg::OP_OR:    alu_res = rs1 | rs2;
      riscv_pkg::OP_XOR:   alu_res = rs1 ^ rs2;
      riscv_pkg::OP_CSRRS: csr_new = rs1 | rs2;
      riscv_pkg::OP_CSRRC: csr_new = rs1 & rs2;
      default:             csr_new = rs1;
    endcase
  end

  // ----------------------------------------------------------------------
  // Forwards of the instruction in execute
  // ----------------------------------------------------------------------
  assign exe_fwd_o.v    = dec_exe_i.rd_v;
  assign exe_fwd_o.adr  = dec_exe_i.rd_adr;
  // CSR ops return the old CSR value, which travels in rs2
  assign exe_fwd_o.data = (dec_exe_i.unit == riscv_pkg::UNIT_CSR) ? rs2 : alu_res;

  assign csr_fwd_o.v    = dec_exe_i.csr_wbk;
  assign csr_fwd_o.adr  = dec_exe_i.csr_adr;
  assign csr_fwd_o.data = csr_new;

  // Writeback register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wbk_q_o     <= '0;
      illegal_q_o <= 1'b0;
      ecall_q_o   <= 1'b0;
      mret_q_o    <= 1'b0;
    end else begin
      wbk_q_o     <= exe_fwd_o;
      illegal_q_o <= dec_exe_i.illegal;
      ecall_q_o   <= dec_exe_i.ecall;
      mret_q_o    <= dec_exe_i.mret;
    end
  end

endmodule

//--- hdl/decode_core.sv
`timescale 1ns/1ps

module decode_core #(
  parameter int          NB_CSR   = 4,
  parameter logic [11:0] CSR_BASE = 12'h340
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic [riscv_pkg::XLEN-1:0] instr_i,
  input  logic [riscv_pkg::XLEN-1:0] pc_i,
  input  logic                       flush_i,
  output logic                       wbk_v_o,
  output logic [4:0]                 wbk_adr_o,
  output logic [riscv_pkg::XLEN-1:0] wbk_data_o,
  output logic                       illegal_o,
  output logic                       ecall_o,
  output logic                       mret_o
);

  logic [4:0]                 rf_rs1_adr;
  logic [4:0]                 rf_rs2_adr;
  logic [riscv_pkg::XLEN-1:0] rf_rs1_data;
  logic [riscv_pkg::XLEN-1:0] rf_rs2_data;
  logic [11:0]                csr_adr;
  logic [riscv_pkg::XLEN-1:0] csr_data;
  pipe_pkg::dec_exe_t         dec_exe_q;
  pipe_pkg::fwd_t             exe_fwd;
  pipe_pkg::csr_fwd_t         csr_fwd;
  // Writeback doubles as RF write port and forward source
  pipe_pkg::fwd_t             wbk;

  dec #(
    .NB_CSR   (NB_CSR),
    .CSR_BASE (CSR_BASE)
  ) i_dec (
    .clk           (clk),
    .reset_n       (reset_n),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .flush_i       (flush_i),
    .rf_rs1_adr_o  (rf_rs1_adr),
    .rf_rs2_adr_o  (rf_rs2_adr),
    .rf_rs1_data_i (rf_rs1_data),
    .rf_rs2_data_i (rf_rs2_data),
    .csr_adr_o     (csr_adr),
    .csr_data_i    (csr_data),
    .exe_fwd_i     (exe_fwd),
    .csr_fwd_i     (csr_fwd),
    .wbk_fwd_i     (wbk),
    .dec_exe_q_o   (dec_exe_q)
  );

  reg_file i_reg_file (
    .clk        (clk),
    .reset_n    (reset_n),
    .rs1_adr_i  (rf_rs1_adr),
    .rs2_adr_i  (rf_rs2_adr),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data),
    .wr_i       (wbk)
  );

  csr_file #(
    .NB_CSR   (NB_CSR),
    .CSR_BASE (CSR_BASE)
  ) i_csr_file (
    .clk       (clk),
    .reset_n   (reset_n),
    .rd_adr_i  (csr_adr),
    .rd_data_o (csr_data),
    .wr_i      (csr_fwd)
  );

  exe i_exe (
    .clk         (clk),
    .reset_n     (reset_n),
    .dec_exe_i   (dec_exe_q),
    .exe_fwd_o   (exe_fwd),
    .csr_fwd_o   (csr_fwd),
    .wbk_q_o     (wbk),
    .illegal_q_o (illegal_o),
    .ecall_q_o   (ecall_o),
    .mret_q_o    (mret_o)
  );

  assign wbk_v_o    = wbk.v;
  assign wbk_adr_o  = wbk.adr;
  assign wbk_data_o = wbk.data;

endmodule

//--- bench/decode_core_properties.sv
`timescale 1ns/1ps

module decode_core_properties (
  input logic       clk,
  input logic       reset_n,
  input logic       flush_i,
  input logic       wbk_v_o,
  input logic [4:0] wbk_adr_o,
  input logic       illegal_o,
  input logic       ecall_o,
  input logic       mret_o
);

  logic out_any;
  // Number of failed assertions
  int   fail_count = 0;

  assign out_any = wbk_v_o || illegal_o || ecall_o || mret_o;

  // Pipeline leaves reset empty
  assert property (@(posedge clk) $rose(reset_n) |-> !out_any ##1 !out_any)
    else begin
      $error("Output valid or flag active right after reset");
      fail_count++;
    end

  // x0 is never written
  assert property (@(posedge clk) disable iff (!reset_n) wbk_v_o |-> wbk_adr_o != 5'd0)
    else begin
      $error("Writeback valid with destination x0");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!reset_n) $onehot0({illegal_o, ecall_o, mret_o}))
    else begin
      $error("More than one exception flag active");
      fail_count++;
    end

  // A flushed instruction reaches the outputs two edges later
  assert property (@(posedge clk) disable iff (!reset_n) flush_i |-> ##2 !out_any)
    else begin
      $error("Flushed instruction produced a write or a flag");
      fail_count++;
    end

endmodule

//--- bench/decode_core_tb.sv
`timescale 1ns/1ps

module decode_core_tb;

  localparam int          CLK_PERIOD = 4;
  localparam int          NUM_INSTR  = 3000;
  localparam int          NB_CSR     = 4;
  localparam logic [11:0] CSR_BASE   = 12'h340;
  localparam logic [31:0] NOP        = 32'h0000_0013;

  typedef struct packed {
    logic        v;
    logic [4:0]  adr;
    logic [31:0] data;
    logic        illegal;
    logic        ecall;
    logic        mret;
  } result_t;

  logic        clk;
  logic        reset_n;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        flush;
  logic        wbk_v;
  logic [4:0]  wbk_adr;
  logic [31:0] wbk_data;
  logic        illegal;
  logic        ecall;
  logic        mret;

  // Reference state
  logic [31:0] regs [32];
  logic [31:0] csrs [NB_CSR];
  logic        first;
  result_t     exp_q [$];
  logic [31:0] lfsr = 32'h3ec9403d;
  int          errors;
  int          checks;

  decode_core #(
    .NB_CSR   (NB_CSR),
    .CSR_BASE (CSR_BASE)
  ) i_decode_core (
    .clk        (clk),
    .reset_n    (reset_n),
    .instr_i    (instr),
    .pc_i       (pc),
    .flush_i    (flush),
    .wbk_v_o    (wbk_v),
    .wbk_adr_o  (wbk_adr),
    .wbk_data_o (wbk_data),
    .illegal_o  (illegal),
    .ecall_o    (ecall),
    .mret_o     (mret)
  );

  bind decode_core decode_core_properties i_decode_core_properties (
    .clk       (clk),
    .reset_n   (reset_n),
    .flush_i   (flush_i),
    .wbk_v_o   (wbk_v_o),
    .wbk_adr_o (wbk_adr_o),
    .illegal_o (illegal_o),
    .ecall_o   (ecall_o),
    .mret_o    (mret_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #((NUM_INSTR + 60) * CLK_PERIOD);
    $display("Watchdog expired before all instructions were checked");
    $display("Test failed");
    $finish;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  // ---------------------------------------------------------------------
  // Stimulus generation
  // ---------------------------------------------------------------------
  function automatic logic [31:0] build_instr();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [19:0] upper;
    logic [2:0]  f3;
    logic [2:0]  sel;
    logic [2:0]  csel;
    logic [11:0] csr;
    kind = 4'(rand_bits(4));
    rd   = 5'(rand_bits(3));
    rs1  = 5'(rand_bits(3));
    rs2  = 5'(rand_bits(3));
    sel  = 3'(rand_bits(3));
    csel = 3'(rand_bits(3));
    // Boundary values a quarter of the time
    if (rand_bits(2) == 0) begin
      case (2'(rand_bits(2)))
        2'd0: imm = 12'h000;
        2'd1: imm = 12'h7ff;
        2'd2: imm = 12'h800;
        default: imm = 12'hfff;
      endcase
      case (2'(rand_bits(2)))
        2'd0: upper = 20'h00000;
        2'd1: upper = 20'h7ffff;
        2'd2: upper = 20'h80000;
        default: upper = 20'hfffff;
      endcase
    end else begin
      imm   = 12'(rand_bits(12));
      upper = 20'(rand_bits(20));
    end
    // One address just past the implemented bank
    csr = (csel == 3'd7) ? CSR_BASE + NB_CSR : CSR_BASE + 12'(csel % NB_CSR);
    case (kind)
      4'd0: begin
        case (sel[1:0])
          2'd0: return {7'b0, rs2, rs1, 3'b001, rd, riscv_pkg::OPC_OP_IMM};
          2'd1: return {imm, rs1, 3'b010, rd, 7'b0000011};
          2'd2: return {csr, rs1, 3'b101, rd, riscv_pkg::OPC_SYSTEM};
          default: return {7'b0000001, rs2, rs1, 3'b000, rd, riscv_pkg::OPC_OP};
        endcase
      end
      4'd6, 4'd7, 4'd8, 4'd9: begin
        case (sel)
          3'd1: f3 = 3'b010;
          3'd2: f3 = 3'b011;
          3'd3, 3'd7: f3 = 3'b100;
          3'd4: f3 = 3'b110;
          3'd5: f3 = 3'b111;
          default: f3 = 3'b000;
        endcase
        return {imm, rs1, f3, rd, riscv_pkg::OPC_OP_IMM};
      end
      4'd10: return {upper, rd, riscv_pkg::OPC_LUI};
      4'd11: return {upper, rd, riscv_pkg::OPC_AUIPC};
      4'd12, 4'd13: begin
        f3 = (sel[1:0] == 2'd0) ? 3'b001 : {1'b0, sel[1:0]};
        return {csr, rs1, f3, rd, riscv_pkg::OPC_SYSTEM};
      end
      4'd14: return sel[0] ? 32'h3020_0073 : 32'h0000_0073;
      default: begin
        case (sel)
          3'd1: return {7'b0100000, rs2, rs1, 3'b000, rd, riscv_pkg::OPC_OP};
          3'd2: return {7'b0, rs2, rs1, 3'b010, rd, riscv_pkg::OPC_OP};
          3'd3: return {7'b0, rs2, rs1, 3'b011, rd, riscv_pkg::OPC_OP};
          3'd4: return {7'b0, rs2, rs1, 3'b100, rd, riscv_pkg::OPC_OP};
          3'd5: return {7'b0, rs2, rs1, 3'b110, rd, riscv_pkg::OPC_OP};
          3'd6: return {7'b0, rs2, rs1, 3'b111, rd, riscv_pkg::OPC_OP};
          default: return {7'b0, rs2, rs1, 3'b000, rd, riscv_pkg::OPC_OP};
        endcase
      end
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // Reference model, one instruction at a time in program order
  // ---------------------------------------------------------------------
  task automatic model_step(input logic [31:0] w, input logic [31:0] pc_now,
                            input logic fl, output result_t res_o);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic [31:0] old;
    logic        legal;
    logic        has_rd;
    logic        impl;
    int          idx;
    res_o  = '0;
    opc    = w[6:0];
    f3     = w[14:12];
    f7     = w[31:25];
    rd     = w[11:7];
    a      = regs[w[19:15]];
    imm_i  = {{20{w[31]}}, w[31:20]};
    res    = '0;
    legal  = 1'b1;
    has_rd = 1'b1;
    impl   = (w[31:20] >= CSR_BASE) && (w[31:20] < CSR_BASE + NB_CSR);
    idx    = int'(w[31:20] - CSR_BASE);
    case (opc)
      riscv_pkg::OPC_OP, riscv_pkg::OPC_OP_IMM: begin
        b = (opc == riscv_pkg::OPC_OP) ? regs[w[24:20]] : imm_i;
        case (f3)
          3'b000: res = (opc == riscv_pkg::OPC_OP && f7[5]) ? a - b : a + b;
          3'b010: res = {31'b0, $signed(a) < $signed(b)};
          3'b011: res = {31'b0, a < b};
          3'b100: res = a ^ b;
          3'b110: res = a | b;
          3'b111: res = a & b;
          default: legal = 1'b0;
        endcase
        if (opc == riscv_pkg::OPC_OP && !(f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000))) begin
          legal = 1'b0;
        end
      end
      riscv_pkg::OPC_LUI: res = {w[31:12], 12'b0};
      riscv_pkg::OPC_AUIPC: res = pc_now + {w[31:12], 12'b0};
      riscv_pkg::OPC_SYSTEM: begin
        if (w == 32'h0000_0073) begin
          res_o.ecall = !fl;
          has_rd      = 1'b0;
        end else if (w == 32'h3020_0073) begin
          res_o.mret = !fl;
          has_rd     = 1'b0;
        end else if (f3 == 3'b001 || f3 == 3'b010 || f3 == 3'b011) begin
          old = impl ? csrs[idx] : '0;
          res = old;
          // Set and clear with rs1 = x0 leave the CSR alone
          if (impl && !fl && (f3 == 3'b001 || w[19:15] != 5'd0)) begin
            case (f3)
              3'b001: csrs[idx] = a;
              3'b010: csrs[idx] = old | a;
              default: csrs[idx] = old & ~a;
            endcase
          end
        end else begin
          legal = 1'b0;
        end
      end
      default: legal = 1'b0;
    endcase
    if (!fl) begin
      res_o.illegal = !legal && !first;
      res_o.v       = legal && has_rd && rd != 5'd0;
      res_o.adr     = rd;
      res_o.data    = res;
      if (res_o.v) begin
        regs[rd] = res;
      end
    end
    first = 1'b0;
  endtask

  task automatic compare_outputs(input result_t want);
    check_value("wbk_v_o", wbk_v, want.v);
    if (want.v) begin
      check_value("wbk_adr_o", wbk_adr, want.adr);
      check_value("wbk_data_o", wbk_data, want.data);
    end
    check_value("illegal_o", illegal, want.illegal);
    check_value("ecall_o", ecall, want.ecall);
    check_value("mret_o", mret, want.mret);
  endtask

  initial begin : stimulus
    result_t     want;
    logic [31:0] word;
    logic [31:0] pc_next;
    logic        fl;
    int          assert_fails;
    reset_n = 1'b0;
    instr   = NOP;
    pc      = '0;
    flush   = 1'b0;
    errors  = 0;
    checks  = 0;
    first   = 1'b1;
    pc_next = 32'h0000_1000;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < NB_CSR; i++) begin
      csrs[i] = '0;
    end
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    // Instruction driven here is the first one sampled after reset
    for (int n = 0; n < NUM_INSTR + 2; n++) begin
      if (n < NUM_INSTR) begin
        word = build_instr();
        fl   = (rand_bits(3) == 0);
      end else begin
        word = NOP;
        fl   = 1'b0;
      end
      instr <= word;
      pc    <= pc_next;
      flush <= fl;
      model_step(word, pc_next, fl, want);
      exp_q.push_back(want);
      pc_next = pc_next + 32'd4;
      @(negedge clk);
      // Results appear two edges after sampling
      if (exp_q.size() == 3) begin
        compare_outputs(exp_q.pop_front());
      end
      @(posedge clk);
    end
    assert_fails = i_decode_core.i_decode_core_properties.fail_count;
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- decode_core.f
hdl/riscv_pkg.sv
hdl/pipe_pkg.sv
hdl/decoder.sv
hdl/dec.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/exe.sv
hdl/decode_core.sv
bench/decode_core_properties.sv
bench/decode_core_tb.sv

//--- Bender.yml
package:
  name: decode_core

sources:
  # Packages first, then stages, then the top level
  - hdl/riscv_pkg.sv
  - hdl/pipe_pkg.sv
  - hdl/decoder.sv
  - hdl/dec.sv
  - hdl/reg_file.sv
  - hdl/csr_file.sv
  - hdl/exe.sv
  - hdl/decode_core.sv

  - target: test
    files:
      - bench/decode_core_properties.sv
      - bench/decode_core_tb.sv
